// File: hdl/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

////////////////////
// datapath widths
////////////////////

// operand and immediate word.
`define ISSUE_DATA_W 32

// physical register tag for 64 registers.
`define ISSUE_TAG_W 6

////////////////////
// queue depths
////////////////////

// alu traffic is the most common class.
`define ALU_QUEUE_LEN 8

`define MEM_QUEUE_LEN 6     // loads and stores.

`define BRANCH_QUEUE_LEN 4  // branches and jumps.

`define MULT_QUEUE_LEN 4    // multiply and divide.

`endif

// File: hdl/uop_pkg.sv
`include "issue_settings.svh"

package uop_pkg;

    typedef logic [`ISSUE_TAG_W-1:0]  tag_t;   // physical register tag.
    typedef logic [`ISSUE_DATA_W-1:0] word_t;  // operand or immediate.

    // execution unit class that steers dispatch to a queue.
    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_MEM    = 2'd1,
        UNIT_BRANCH = 2'd2,
        UNIT_MULT   = 2'd3
    } unit_e;

    // carried through issue untouched.
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SLT   = 4'h5,
        OP_SLL   = 4'h6,
        OP_SRL   = 4'h7,
        OP_LOAD  = 4'h8,
        OP_STORE = 4'h9,
        OP_BEQ   = 4'ha,
        OP_BNE   = 4'hb,
        OP_JAL   = 4'hc,
        OP_MUL   = 4'hd,
        OP_MULH  = 4'he,
        OP_DIV   = 4'hf
    } op_e;

endpackage

// File: hdl/iq_pkg.sv
package iq_pkg;
    import uop_pkg::*;

    // one source operand whose data is meaningful once ready is set.
    typedef struct packed {
        logic  ready;
        tag_t  tag;
        word_t data;
    } src_t;

    typedef struct packed {
        logic  valid;
        op_e   op;
        tag_t  dst;
        word_t imm;
        src_t  src1;
        src_t  src2;
    } iq_entry_t;

    // result broadcast capture for a waiting slot.
    function automatic src_t wake_capture(src_t s, logic wake_valid, tag_t wake_tag,
                                          word_t wake_data);
        src_t r;
        r = s;
        if (wake_valid && !s.ready && (s.tag == wake_tag)) begin
            r.ready = 1'b1;
            r.data  = wake_data;
        end
        return r;
    endfunction

endpackage

// File: hdl/operand_resolve.sv
`timescale 1ns/1ps

module operand_resolve (
    input  uop_pkg::op_e      dispatch_op,
    input  uop_pkg::tag_t     dispatch_dst,
    input  uop_pkg::word_t    dispatch_imm,
    input  logic              src1_used,
    input  uop_pkg::tag_t     src1_tag,
    input  logic              rf1_ready,
    input  uop_pkg::word_t    rf1_data,
    input  logic              byp1_hit,
    input  uop_pkg::word_t    byp1_data,
    input  logic              src2_used,
    input  uop_pkg::tag_t     src2_tag,
    input  logic              rf2_ready,
    input  uop_pkg::word_t    rf2_data,
    input  logic              byp2_hit,
    input  uop_pkg::word_t    byp2_data,
    input  logic              wake_valid,
    input  uop_pkg::tag_t     wake_tag,
    input  uop_pkg::word_t    wake_data,
    output iq_pkg::iq_entry_t entry
);
    import uop_pkg::*;
    import iq_pkg::*;

    // unused, then bypass, then register file, else wait on the tag.
    function automatic src_t pick_src(logic used, tag_t tag, logic rf_ready, word_t rf_data,
                                      logic byp_hit, word_t byp_data);
        src_t s;
        s.tag = tag;
        if (!used) begin
            s.ready = 1'b1;
            s.data  = '0;
        end else if (byp_hit) begin
            s.ready = 1'b1;
            s.data  = byp_data;
        end else if (rf_ready) begin
            s.ready = 1'b1;
            s.data  = rf_data;
        end else begin
            s.ready = 1'b0;
            s.data  = '0;
        end
        return s;
    endfunction

    src_t src1_pick;
    src_t src2_pick;

    assign src1_pick = pick_src(src1_used, src1_tag, rf1_ready, rf1_data, byp1_hit, byp1_data);
    assign src2_pick = pick_src(src2_used, src2_tag, rf2_ready, rf2_data, byp2_hit, byp2_data);

    always_comb begin
        entry.valid = 1'b1;
        entry.op    = dispatch_op;
        entry.dst   = dispatch_dst;
        entry.imm   = dispatch_imm;
        // the queue wakes only stored slots, so a broadcast now would miss the new entry.
        entry.src1  = wake_capture(src1_pick, wake_valid, wake_tag, wake_data);
        entry.src2  = wake_capture(src2_pick, wake_valid, wake_tag, wake_data);
    end

endmodule

// File: hdl/issue_queue.sv
`timescale 1ns/1ps

module issue_queue #(
    parameter int QUEUE_LEN = 4
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              write,
    input  iq_pkg::iq_entry_t write_entry,
    input  logic              wake_valid,
    input  uop_pkg::tag_t     wake_tag,
    input  uop_pkg::word_t    wake_data,
    input  logic              busy,
    output logic              full,
    output logic              issue_valid,
    output uop_pkg::op_e      issue_op,
    output uop_pkg::tag_t     issue_dst,
    output uop_pkg::word_t    issue_imm,
    output uop_pkg::word_t    issue_src1,
    output uop_pkg::word_t    issue_src2
);
    import iq_pkg::*;

    localparam int IDX_W = (QUEUE_LEN > 1) ? $clog2(QUEUE_LEN) : 1;

    iq_entry_t            slot     [QUEUE_LEN];  // index 0 holds the oldest entry.
    iq_entry_t            woken    [QUEUE_LEN];
    iq_entry_t            nxt_slot [QUEUE_LEN];
    logic [QUEUE_LEN-1:0] vld;
    logic [QUEUE_LEN-1:0] nxt_vld;
    logic [QUEUE_LEN-1:0] ready;
    logic                 sel_hit;
    logic [IDX_W-1:0]     sel_idx;
    logic                 accept;

    // occupancy is contiguous from slot 0.
    assign full   = vld[QUEUE_LEN-1];
    assign accept = write && write_entry.valid && !full;

    ////////////////////
    // wakeup
    ////////////////////

    always_comb begin
        for (int i = 0; i < QUEUE_LEN; i++) begin
            woken[i]      = slot[i];
            woken[i].src1 = wake_capture(slot[i].src1, wake_valid, wake_tag, wake_data);
            woken[i].src2 = wake_capture(slot[i].src2, wake_valid, wake_tag, wake_data);
            ready[i]      = vld[i] && slot[i].src1.ready && slot[i].src2.ready;
        end
    end

    ////////////////////
    // oldest-ready select
    ////////////////////

    always_comb begin
        sel_hit = 1'b0;
        sel_idx = '0;
        if (!busy) begin
            for (int i = QUEUE_LEN - 1; i >= 0; i--) begin
                if (ready[i]) begin  // lowest index wins.
                    sel_hit = 1'b1;
                    sel_idx = IDX_W'(i);
                end
            end
        end
    end

    ////////////////////
    // collapse and append
    ////////////////////

    always_comb begin
        int   src;
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < QUEUE_LEN; i++) begin
            src = (sel_hit && (i >= int'(sel_idx))) ? i + 1 : i;  // close the gap.
            if (src < QUEUE_LEN) begin
                nxt_vld[i]  = vld[src];
                nxt_slot[i] = woken[src];
            end else begin
                nxt_vld[i]  = 1'b0;
                nxt_slot[i] = woken[i];
            end
            // first free slot after the shift is the tail.
            if (accept && !placed && !nxt_vld[i]) begin
                nxt_vld[i]  = 1'b1;
                nxt_slot[i] = write_entry;
                placed      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld         <= '0;
            issue_valid <= 1'b0;
        end else begin
            vld         <= nxt_vld;
            issue_valid <= sel_hit;
        end
    end

    always_ff @(posedge clk) begin
        slot <= nxt_slot;
        if (sel_hit) begin  // hold the last issued entry otherwise.
            issue_op   <= slot[sel_idx].op;
            issue_dst  <= slot[sel_idx].dst;
            issue_imm  <= slot[sel_idx].imm;
            issue_src1 <= slot[sel_idx].src1.data;
            issue_src2 <= slot[sel_idx].src2.data;
        end
    end

endmodule

// File: hdl/issue_stage.sv
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           dispatch_valid,
    input  uop_pkg::unit_e dispatch_unit,
    input  uop_pkg::op_e   dispatch_op,
    input  uop_pkg::tag_t  dispatch_dst,
    input  uop_pkg::word_t dispatch_imm,
    input  logic           src1_used,
    input  uop_pkg::tag_t  src1_tag,
    input  logic           rf1_ready,
    input  uop_pkg::word_t rf1_data,
    input  logic           byp1_hit,
    input  uop_pkg::word_t byp1_data,
    input  logic           src2_used,
    input  uop_pkg::tag_t  src2_tag,
    input  logic           rf2_ready,
    input  uop_pkg::word_t rf2_data,
    input  logic           byp2_hit,
    input  uop_pkg::word_t byp2_data,
    input  logic           wake_valid,
    input  uop_pkg::tag_t  wake_tag,
    input  uop_pkg::word_t wake_data,
    input  logic           alu_busy,
    input  logic           mem_busy,
    input  logic           br_busy,
    input  logic           mul_busy,
    output logic           alu_full,
    output logic           alu_issue_valid,
    output uop_pkg::op_e   alu_issue_op,
    output uop_pkg::tag_t  alu_issue_dst,
    output uop_pkg::word_t alu_issue_imm,
    output uop_pkg::word_t alu_issue_src1,
    output uop_pkg::word_t alu_issue_src2,
    output logic           mem_full,
    output logic           mem_issue_valid,
    output uop_pkg::op_e   mem_issue_op,
    output uop_pkg::tag_t  mem_issue_dst,
    output uop_pkg::word_t mem_issue_imm,
    output uop_pkg::word_t mem_issue_src1,
    output uop_pkg::word_t mem_issue_src2,
    output logic           br_full,
    output logic           br_issue_valid,
    output uop_pkg::op_e   br_issue_op,
    output uop_pkg::tag_t  br_issue_dst,
    output uop_pkg::word_t br_issue_imm,
    output uop_pkg::word_t br_issue_src1,
    output uop_pkg::word_t br_issue_src2,
    output logic           mul_full,
    output logic           mul_issue_valid,
    output uop_pkg::op_e   mul_issue_op,
    output uop_pkg::tag_t  mul_issue_dst,
    output uop_pkg::word_t mul_issue_imm,
    output uop_pkg::word_t mul_issue_src1,
    output uop_pkg::word_t mul_issue_src2
);
    import uop_pkg::*;
    import iq_pkg::*;

    iq_entry_t entry;
    logic      alu_write;
    logic      mem_write;
    logic      br_write;
    logic      mul_write;

    operand_resolve resolve (
        .dispatch_op, .dispatch_dst, .dispatch_imm,
        .src1_used, .src1_tag, .rf1_ready, .rf1_data, .byp1_hit, .byp1_data,
        .src2_used, .src2_tag, .rf2_ready, .rf2_data, .byp2_hit, .byp2_data,
        .wake_valid, .wake_tag, .wake_data,
        .entry
    );

    ////////////////////
    // dispatch steering
    ////////////////////

    assign alu_write = dispatch_valid && (dispatch_unit == UNIT_ALU);
    assign mem_write = dispatch_valid && (dispatch_unit == UNIT_MEM);
    assign br_write  = dispatch_valid && (dispatch_unit == UNIT_BRANCH);
    assign mul_write = dispatch_valid && (dispatch_unit == UNIT_MULT);

    // every queue sees the same broadcast.
    issue_queue #(.QUEUE_LEN(`ALU_QUEUE_LEN)) alu_queue (
        .clk, .arst_n, .write(alu_write), .write_entry(entry),
        .wake_valid, .wake_tag, .wake_data, .busy(alu_busy),
        .full(alu_full), .issue_valid(alu_issue_valid), .issue_op(alu_issue_op),
        .issue_dst(alu_issue_dst), .issue_imm(alu_issue_imm),
        .issue_src1(alu_issue_src1), .issue_src2(alu_issue_src2)
    );

    issue_queue #(.QUEUE_LEN(`MEM_QUEUE_LEN)) mem_queue (
        .clk, .arst_n, .write(mem_write), .write_entry(entry),
        .wake_valid, .wake_tag, .wake_data, .busy(mem_busy),
        .full(mem_full), .issue_valid(mem_issue_valid), .issue_op(mem_issue_op),
        .issue_dst(mem_issue_dst), .issue_imm(mem_issue_imm),
        .issue_src1(mem_issue_src1), .issue_src2(mem_issue_src2)
    );

    issue_queue #(.QUEUE_LEN(`BRANCH_QUEUE_LEN)) br_queue (
        .clk, .arst_n, .write(br_write), .write_entry(entry),
        .wake_valid, .wake_tag, .wake_data, .busy(br_busy),
        .full(br_full), .issue_valid(br_issue_valid), .issue_op(br_issue_op),
        .issue_dst(br_issue_dst), .issue_imm(br_issue_imm),
        .issue_src1(br_issue_src1), .issue_src2(br_issue_src2)
    );

    issue_queue #(.QUEUE_LEN(`MULT_QUEUE_LEN)) mul_queue (
        .clk, .arst_n, .write(mul_write), .write_entry(entry),
        .wake_valid, .wake_tag, .wake_data, .busy(mul_busy),
        .full(mul_full), .issue_valid(mul_issue_valid), .issue_op(mul_issue_op),
        .issue_dst(mul_issue_dst), .issue_imm(mul_issue_imm),
        .issue_src1(mul_issue_src1), .issue_src2(mul_issue_src2)
    );

endmodule

// File: bench/issue_stage_properties.sv
`timescale 1ns/1ps

module issue_stage_properties (
    input logic           clk,
    input logic           arst_n,
    input logic           dispatch_valid,
    input uop_pkg::unit_e dispatch_unit,
    input logic           alu_full, mem_full, br_full, mul_full,
    input logic           alu_busy, mem_busy, br_busy, mul_busy,
    input logic           alu_issue_valid, mem_issue_valid, br_issue_valid, mul_issue_valid,
    input uop_pkg::word_t alu_issue_src1, alu_issue_src2, mem_issue_src1, mem_issue_src2,
    input uop_pkg::word_t br_issue_src1, br_issue_src2, mul_issue_src1, mul_issue_src2
);
    import uop_pkg::*;

    logic unit_full;
    logic any_issue;

    assign unit_full = (dispatch_unit == UNIT_ALU) ? alu_full :
                       (dispatch_unit == UNIT_MEM) ? mem_full :
                       (dispatch_unit == UNIT_BRANCH) ? br_full : mul_full;
    assign any_issue = alu_issue_valid || mem_issue_valid || br_issue_valid || mul_issue_valid;

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !any_issue)
        else $error("issue_valid high during reset");
    no_full_write: assert property (@(posedge clk) disable iff (!arst_n)
        dispatch_valid |-> !unit_full) else $error("dispatch to a full queue");

    ////////////////////
    // back-pressure
    ////////////////////

    alu_hold: assert property (@(posedge clk) disable iff (!arst_n)
        alu_busy |=> !alu_issue_valid) else $error("alu issued after busy");
    mem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_busy |=> !mem_issue_valid) else $error("mem issued after busy");
    br_hold: assert property (@(posedge clk) disable iff (!arst_n)
        br_busy |=> !br_issue_valid) else $error("branch issued after busy");
    mul_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mul_busy |=> !mul_issue_valid) else $error("mult issued after busy");

    // issued operands carry known data.
    alu_known: assert property (@(posedge clk) disable iff (!arst_n)
        alu_issue_valid |-> !$isunknown({alu_issue_src1, alu_issue_src2}))
        else $error("alu issued unknown operand data");
    mem_known: assert property (@(posedge clk) disable iff (!arst_n)
        mem_issue_valid |-> !$isunknown({mem_issue_src1, mem_issue_src2}))
        else $error("mem issued unknown operand data");
    br_known: assert property (@(posedge clk) disable iff (!arst_n)
        br_issue_valid |-> !$isunknown({br_issue_src1, br_issue_src2}))
        else $error("branch issued unknown operand data");
    mul_known: assert property (@(posedge clk) disable iff (!arst_n)
        mul_issue_valid |-> !$isunknown({mul_issue_src1, mul_issue_src2}))
        else $error("mult issued unknown operand data");

endmodule

bind issue_stage issue_stage_properties props (.*);

// File: bench/issue_stage_tb.sv
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_stage_tb;
    import uop_pkg::*;

    localparam int MAX_UOPS = 1024;

    logic  clk, arst_n, dispatch_valid, wake_valid;
    unit_e dispatch_unit;
    op_e   dispatch_op;
    tag_t  dispatch_dst, src1_tag, src2_tag, wake_tag;
    word_t dispatch_imm, rf1_data, byp1_data, rf2_data, byp2_data, wake_data;
    logic  src1_used, rf1_ready, byp1_hit, src2_used, rf2_ready, byp2_hit;
    logic  alu_busy, mem_busy, br_busy, mul_busy;
    logic  alu_full, mem_full, br_full, mul_full;
    logic  alu_issue_valid, mem_issue_valid, br_issue_valid, mul_issue_valid;
    op_e   alu_issue_op, mem_issue_op, br_issue_op, mul_issue_op;
    tag_t  alu_issue_dst, mem_issue_dst, br_issue_dst, mul_issue_dst;
    word_t alu_issue_imm, mem_issue_imm, br_issue_imm, mul_issue_imm;
    word_t alu_issue_src1, mem_issue_src1, br_issue_src1, mul_issue_src1;
    word_t alu_issue_src2, mem_issue_src2, br_issue_src2, mul_issue_src2;

    // register model and dispatched micro-ops, indexed by sequence id (also the imm).
    word_t reg_val   [64];
    logic  reg_ready [64];
    int    wake_cyc  [64];
    int    u_unit [MAX_UOPS];
    op_e   u_op   [MAX_UOPS];
    tag_t  u_dst  [MAX_UOPS];
    logic  u_used1 [MAX_UOPS], u_used2 [MAX_UOPS], u_wait1 [MAX_UOPS], u_wait2 [MAX_UOPS];
    tag_t  u_tag1 [MAX_UOPS], u_tag2 [MAX_UOPS];
    int    u_disp [MAX_UOPS];
    int    pend_q [$];  // dispatch order.

    int          next_id, cyc, mismatch_count, other_count;
    logic [31:0] rng;
    logic [3:0]  last_busy;
    string       cur_test;

    // values for the next cycle.
    logic       st_disp, st_used1, st_byp1, st_used2, st_byp2, st_wake;
    int         st_unit;
    tag_t       st_tag1, st_tag2, st_wake_tag;
    logic [3:0] st_busy;

    issue_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic word_t expected_operand(logic used, tag_t tag);
        return used ? reg_val[tag] : '0;
    endfunction

    function automatic int depth_of(int u);
        case (u)
            0: return `ALU_QUEUE_LEN;
            1: return `MEM_QUEUE_LEN;
            2: return `BRANCH_QUEUE_LEN;
            default: return `MULT_QUEUE_LEN;
        endcase
    endfunction

    // first cycle in which the entry sits in its queue with both sources ready.
    function automatic int eligible_cycle(int id);
        int e;
        e = u_disp[id] + 1;
        if (u_wait1[id]) begin
            if (!reg_ready[u_tag1[id]]) return 1 << 30;
            if (wake_cyc[u_tag1[id]] + 1 > e) e = wake_cyc[u_tag1[id]] + 1;
        end
        if (u_wait2[id]) begin
            if (!reg_ready[u_tag2[id]]) return 1 << 30;
            if (wake_cyc[u_tag2[id]] + 1 > e) e = wake_cyc[u_tag2[id]] + 1;
        end
        return e;
    endfunction

    function automatic int oldest_ready(int u, int s);
        foreach (pend_q[i]) begin
            if (u_unit[pend_q[i]] == u && eligible_cycle(pend_q[i]) <= s) return i;
        end
        return -1;
    endfunction

    function automatic int count_pending(int u);
        int n;
        n = 0;
        foreach (pend_q[i]) begin
            if (u_unit[pend_q[i]] == u) n++;
        end
        return n;
    endfunction

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic compare_op(string what, op_e exp, op_e act);
        if (exp !== act) begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_tag(string what, tag_t exp, tag_t act);
        if (exp !== act) begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %0h actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_word(string what, word_t exp, word_t act);
        if (exp !== act) begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %08h actual %08h", cur_test, what, exp, act);
        end
    endtask

    task automatic compare_flag(string what, logic exp, logic act);
        if (exp !== act) begin
            mismatch_count++;
            $display("Mismatch %s %s: expected %0b actual %0b", cur_test, what, exp, act);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    task automatic reinit_model();
        for (int t = 0; t < 64; t++) begin
            reg_val[t]   = rand32();
            reg_ready[t] = 1'b0;
            wake_cyc[t]  = 0;
        end
    endtask

    task automatic stage_uop(int unit, logic used1, tag_t tag1, logic byp1,
                             logic used2, tag_t tag2, logic byp2);
        st_disp  = 1'b1;
        st_unit  = unit;
        st_used1 = used1;
        st_tag1  = tag1;
        st_byp1  = byp1;
        st_used2 = used2;
        st_tag2  = tag2;
        st_byp2  = byp2;
    endtask

    task automatic wake_now(tag_t tag);
        st_wake     = 1'b1;
        st_wake_tag = tag;
    endtask

    // drive the staged cycle for one clock and update the model.
    task automatic tick();
        int id;
        int now;
        @(posedge clk);
        now = cyc + 1;
        dispatch_valid <= st_disp;
        dispatch_unit  <= unit_e'(2'(st_unit));
        if (st_disp) begin
            id = next_id;
            next_id++;
            u_unit[id]  = st_unit;
            u_op[id]    = op_e'(4'(rand32()));
            u_dst[id]   = tag_t'(rand32());
            u_used1[id] = st_used1;
            u_tag1[id]  = st_tag1;
            u_wait1[id] = st_used1 && !st_byp1 && !reg_ready[st_tag1];
            u_used2[id] = st_used2;
            u_tag2[id]  = st_tag2;
            u_wait2[id] = st_used2 && !st_byp2 && !reg_ready[st_tag2];
            u_disp[id]  = now;
            pend_q.push_back(id);
            dispatch_op  <= u_op[id];
            dispatch_dst <= u_dst[id];
            dispatch_imm <= word_t'(id);
        end
        src1_used <= st_used1;
        src1_tag  <= st_tag1;
        rf1_ready <= reg_ready[st_tag1];
        rf1_data  <= (reg_ready[st_tag1] && !st_byp1) ? reg_val[st_tag1] : ~reg_val[st_tag1];
        byp1_hit  <= st_byp1;
        byp1_data <= reg_val[st_tag1];
        src2_used <= st_used2;
        src2_tag  <= st_tag2;
        rf2_ready <= reg_ready[st_tag2];
        rf2_data  <= (reg_ready[st_tag2] && !st_byp2) ? reg_val[st_tag2] : ~reg_val[st_tag2];
        byp2_hit  <= st_byp2;
        byp2_data <= reg_val[st_tag2];
        wake_tag  <= st_wake_tag;
        wake_data <= reg_val[st_wake_tag];
        if (st_wake && !reg_ready[st_wake_tag]) begin  // each tag is produced once.
            wake_valid <= 1'b1;
            reg_ready[st_wake_tag] = 1'b1;
            wake_cyc[st_wake_tag]  = now;
        end else begin
            wake_valid <= 1'b0;
        end
        alu_busy <= st_busy[0];
        mem_busy <= st_busy[1];
        br_busy  <= st_busy[2];
        mul_busy <= st_busy[3];
        st_disp = 1'b0;
        st_wake = 1'b0;
        st_byp1 = 1'b0;
        st_byp2 = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) tick();
    endtask

    // release busy and produce tags until the queues are empty.
    task automatic drain();
        int n;
        int t;
        n = 0;
        t = 0;
        st_busy = '0;
        while (pend_q.size() != 0 && n < 400) begin
            while (t < 64 && reg_ready[t]) t++;
            if (t < 64) wake_now(tag_t'(t));
            tick();
            n++;
        end
        if (pend_q.size() != 0) begin
            other_count++;
            $display("Timeout in %s: %0d micro-ops never issued", cur_test, pend_q.size());
            pend_q.delete();
        end
    endtask

    task automatic check_full(int u, logic exp);
        logic act;
        @(negedge clk);
        case (u)
            0: act = alu_full;
            1: act = mem_full;
            2: act = br_full;
            default: act = mul_full;
        endcase
        compare_flag("full", exp, act);
    endtask

    ////////////////////
    // scoreboard
    ////////////////////

    always @(negedge clk) begin : check_issue
        logic  v;
        op_e   op;
        tag_t  dst;
        word_t imm, s1, s2;
        int    idx;
        int    id;
        if (arst_n) begin
            for (int u = 0; u < 4; u++) begin
                case (u)
                    0: {v, op, dst, imm, s1, s2} = {alu_issue_valid, alu_issue_op,
                        alu_issue_dst, alu_issue_imm, alu_issue_src1, alu_issue_src2};
                    1: {v, op, dst, imm, s1, s2} = {mem_issue_valid, mem_issue_op,
                        mem_issue_dst, mem_issue_imm, mem_issue_src1, mem_issue_src2};
                    2: {v, op, dst, imm, s1, s2} = {br_issue_valid, br_issue_op,
                        br_issue_dst, br_issue_imm, br_issue_src1, br_issue_src2};
                    default: {v, op, dst, imm, s1, s2} = {mul_issue_valid, mul_issue_op,
                        mul_issue_dst, mul_issue_imm, mul_issue_src1, mul_issue_src2};
                endcase
                idx = oldest_ready(u, cyc - 1);  // select happened last cycle.
                if (last_busy[u]) begin
                    if (v) begin
                        other_count++;
                        $display("Error in %s: unit %0d issued right after busy", cur_test, u);
                    end
                end else if (idx < 0) begin
                    if (v) begin
                        other_count++;
                        $display("Error in %s: unit %0d issued with nothing ready", cur_test, u);
                    end
                end else if (!v) begin
                    other_count++;
                    $display("Error in %s: unit %0d did not issue micro-op %0d", cur_test, u,
                             pend_q[idx]);
                end else begin
                    id = pend_q[idx];
                    compare_op("op", u_op[id], op);
                    compare_tag("dst", u_dst[id], dst);
                    compare_word("imm", word_t'(id), imm);
                    compare_word("src1", expected_operand(u_used1[id], u_tag1[id]), s1);
                    compare_word("src2", expected_operand(u_used2[id], u_tag2[id]), s2);
                    pend_q.delete(idx);
                end
            end
        end
        last_busy = {mul_busy, br_busy, mem_busy, alu_busy};
    end

    ////////////////////
    // tests
    ////////////////////

    initial begin : main
        logic [31:0] r;
        logic [31:0] r2;
        int          n;
        int          c;
        rng = 32'hfd1e_901a;
        {cyc, next_id, mismatch_count, other_count} = '0;
        last_busy = '0;
        {st_disp, st_used1, st_byp1, st_used2, st_byp2, st_wake} = '0;
        {st_unit, st_tag1, st_tag2, st_wake_tag, st_busy} = '0;
        arst_n = 1'b0;
        {dispatch_valid, dispatch_unit, dispatch_op, dispatch_dst, dispatch_imm} = '0;
        {src1_used, src1_tag, rf1_ready, rf1_data, byp1_hit, byp1_data} = '0;
        {src2_used, src2_tag, rf2_ready, rf2_data, byp2_hit, byp2_data} = '0;
        {wake_valid, wake_tag, wake_data} = '0;
        {alu_busy, mem_busy, br_busy, mul_busy} = '0;
        reinit_model();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        tick();

        cur_test = "rf_ready";  // one ready micro-op for each unit.
        wake_now(1);
        tick();
        wake_now(2);
        tick();
        for (int u = 0; u < 4; u++) begin
            stage_uop(u, 1'b1, 1, 1'b0, 1'b1, 2, 1'b0);
            tick();
        end
        drain();

        reinit_model();
        cur_test = "bypass";
        wake_now(3);
        tick();
        stage_uop(0, 1'b1, 3, 1'b1, 1'b1, 5, 1'b1);
        tick();
        drain();

        reinit_model();
        cur_test = "wake";
        stage_uop(1, 1'b1, 10, 1'b0, 1'b0, 0, 1'b0);
        tick();
        idle(3);
        wake_now(10);
        tick();
        stage_uop(2, 1'b1, 11, 1'b0, 1'b1, 12, 1'b0);
        wake_now(11);  // same cycle as the dispatch.
        tick();
        idle(2);
        wake_now(12);
        tick();
        drain();

        reinit_model();
        cur_test = "order";
        stage_uop(3, 1'b1, 20, 1'b0, 1'b0, 0, 1'b0);
        tick();
        for (n = 0; n < 3; n++) begin
            stage_uop(3, 1'b0, 0, 1'b0, 1'b0, 0, 1'b0);
            tick();
        end
        idle(4);
        wake_now(20);
        tick();
        drain();

        // sources read the register file or wait for a tag that the drain produces.
        cur_test = "busy_full";
        for (int u = 0; u < 4; u++) begin
            st_busy[u] = 1'b1;
            for (n = 1; n <= depth_of(u); n++) begin
                stage_uop(u, 1'b1, tag_t'(n), 1'b0, 1'b1, tag_t'(n + 8), 1'b0);
                tick();
                tick();
                check_full(u, n == depth_of(u));
            end
            idle(3);
            drain();
        end

        reinit_model();
        cur_test = "random";
        n = 0;
        for (c = 0; n < 300 && c < 3000; c++) begin
            st_busy = 4'(rand32()) & 4'(rand32()) & 4'(rand32());
            r  = rand32();
            r2 = rand32();
            if (r[0]) wake_now(tag_t'(r[13:8]));
            if (r[19:18] != 2'd0 && count_pending(int'(r[17:16])) < depth_of(int'(r[17:16])))
            begin
                stage_uop(int'(r[17:16]), r[20] | r[21], tag_t'(r[27:22]), r[28] & r[29],
                          r[30] | r[31], tag_t'(r2[5:0]), r2[6] & r2[7]);
                n++;
            end
            tick();
        end
        if (n < 300) begin
            other_count++;
            $display("Timeout in %s: only %0d micro-ops dispatched", cur_test, n);
        end
        drain();
        idle(2);

        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/uop_pkg.sv
hdl/iq_pkg.sv
hdl/operand_resolve.sv
hdl/issue_queue.sv
hdl/issue_stage.sv
bench/issue_stage_properties.sv
bench/issue_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, then scan the log.
rm -rf obj_dir sim.log
verilator --binary --assert --top-module issue_stage_tb -f project.f -o issue_sim &&
    ./obj_dir/issue_sim > sim.log 2>&1 ||
    echo "build or simulation stopped early"
cat sim.log 2>/dev/null
grep -q "STATUS: FAIL" sim.log 2>/dev/null && exit 1
grep -q "STATUS: PASS" sim.log 2>/dev/null || exit 1
exit 0
